//--- design/alu_pkg.sv
// Shared widths, operation encodings and the operation word for the scalar execute stage
package alu_pkg;

    // Lane and field widths of one warp instruction
    localparam int num_lanes = 4;
    localparam int xlen      = 32;
    localparam int wid_bits  = 2;
    localparam int uuid_bits = 8;
    localparam int nr_bits   = 5;

    // Integer and branch operations handled by the integer unit
    typedef enum logic [3:0] {
        op_add  = 4'd0,
        op_sub  = 4'd1,
        op_and  = 4'd2,
        op_or   = 4'd3,
        op_xor  = 4'd4,
        op_sll  = 4'd5,
        op_srl  = 4'd6,
        op_sra  = 4'd7,
        op_slt  = 4'd8,
        op_sltu = 4'd9,
        op_beq  = 4'd10,
        op_bne  = 4'd11,
        op_blt  = 4'd12,
        op_bge  = 4'd13
    } alu_op_e;

    // Multiply and divide operations handled by the iterative unit
    typedef enum logic [3:0] {
        op_mul   = 4'd0,
        op_mulh  = 4'd1,
        op_mulhu = 4'd2,
        op_div   = 4'd3,
        op_divu  = 4'd4,
        op_rem   = 4'd5,
        op_remu  = 4'd6
    } md_op_e;

    // One operation word with two readings, the is_md flag of the
    // instruction tells which one holds
    typedef union packed {
        alu_op_e alu;
        md_op_e  md;
    } op_u;

    // Branches compare lane 0 and write the link value in every lane
    function automatic logic is_branch(alu_op_e op);
        return op inside {op_beq, op_bne, op_blt, op_bge};
    endfunction

    // Divide and remainder that treat their operands as signed
    function automatic logic is_signed_div(md_op_e op);
        return op inside {op_div, op_rem};
    endfunction

    function automatic logic is_mul(md_op_e op);
        return op inside {op_mul, op_mulh, op_mulhu};
    endfunction

endpackage

//--- design/execute_if.sv
// Instruction stream from the class splitter to one execute unit
`timescale 1ns/1ps

interface execute_if;
    import alu_pkg::*;

    logic                           valid;
    logic                           ready;
    logic [uuid_bits-1:0]           uuid;
    logic [wid_bits-1:0]            wid;
    logic [num_lanes-1:0]           tmask;
    logic [xlen-1:0]                pc;
    logic [nr_bits-1:0]             rd;
    logic                           wb;
    op_u                            op;
    logic [num_lanes-1:0][xlen-1:0] rs1_data;
    logic [num_lanes-1:0][xlen-1:0] rs2_data;
    logic [xlen-1:0]                offset;

    // The splitter drives the instruction and the unit answers with ready
    modport master (
        output valid, uuid, wid, tmask, pc, rd, wb, op, rs1_data, rs2_data, offset,
        input  ready
    );

    modport slave (
        input  valid, uuid, wid, tmask, pc, rd, wb, op, rs1_data, rs2_data, offset,
        output ready
    );

endinterface

//--- design/commit_if.sv
// Result stream from an execute unit toward the commit port
`timescale 1ns/1ps

interface commit_if;
    import alu_pkg::*;

    logic                           valid;
    logic                           ready;
    logic [uuid_bits-1:0]           uuid;
    logic [wid_bits-1:0]            wid;
    logic [num_lanes-1:0]           tmask;
    logic [xlen-1:0]                pc;
    logic [nr_bits-1:0]             rd;
    logic                           wb;
    logic [num_lanes-1:0][xlen-1:0] data;

    // Units produce results, the arbiter consumes them
    modport master (
        output valid, uuid, wid, tmask, pc, rd, wb, data,
        input  ready
    );

    modport slave (
        input  valid, uuid, wid, tmask, pc, rd, wb, data,
        output ready
    );

endinterface

//--- design/int_unit.sv
// Two-stage integer and branch unit, all lanes computed in parallel
`timescale 1ns/1ps

module int_unit (
    input  logic                       clk,
    input  logic                       reset,
    execute_if.slave                   exec,
    commit_if.master                   commit,
    output logic                       branch_valid,
    output logic [alu_pkg::wid_bits-1:0] branch_wid,
    output logic                       branch_taken,
    output logic [alu_pkg::xlen-1:0]   branch_dest
);
    import alu_pkg::*;

    logic                           s1_valid;
    logic                           s1_adv;
    logic [uuid_bits-1:0]           s1_uuid;
    logic [wid_bits-1:0]            s1_wid;
    logic [num_lanes-1:0]           s1_tmask;
    logic [xlen-1:0]                s1_pc;
    logic [nr_bits-1:0]             s1_rd;
    logic                           s1_wb;
    alu_op_e                        s1_op;
    logic [num_lanes-1:0][xlen-1:0] s1_rs1;
    logic [num_lanes-1:0][xlen-1:0] s1_rs2;
    logic [xlen-1:0]                s1_offset;
    logic [num_lanes-1:0][xlen-1:0] s1_res;

    // Stage one moves on when the output register is empty or drains this cycle
    assign s1_adv     = !commit.valid || commit.ready;
    assign exec.ready = !s1_valid || s1_adv;

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid     <= 1'b0;
            commit.valid <= 1'b0;
        end else begin
            if (exec.ready)
                s1_valid <= exec.valid;
            if (s1_adv)
                commit.valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (exec.valid && exec.ready) begin
            s1_uuid   <= exec.uuid;
            s1_wid    <= exec.wid;
            s1_tmask  <= exec.tmask;
            s1_pc     <= exec.pc;
            s1_rd     <= exec.rd;
            s1_wb     <= exec.wb;
            s1_op     <= exec.op.alu;
            s1_rs1    <= exec.rs1_data;
            s1_rs2    <= exec.rs2_data;
            s1_offset <= exec.offset;
        end
        // Stage two is the output register itself
        if (s1_valid && s1_adv) begin
            commit.uuid  <= s1_uuid;
            commit.wid   <= s1_wid;
            commit.tmask <= s1_tmask;
            commit.pc    <= s1_pc;
            commit.rd    <= s1_rd;
            commit.wb    <= s1_wb;
            commit.data  <= s1_res;
        end
    end

    always_comb begin
        for (int i = 0; i < num_lanes; i++) begin
            case (s1_op)
                op_add:  s1_res[i] = s1_rs1[i] + s1_rs2[i];
                op_sub:  s1_res[i] = s1_rs1[i] - s1_rs2[i];
                op_and:  s1_res[i] = s1_rs1[i] & s1_rs2[i];
                op_or:   s1_res[i] = s1_rs1[i] | s1_rs2[i];
                op_xor:  s1_res[i] = s1_rs1[i] ^ s1_rs2[i];
                op_sll:  s1_res[i] = s1_rs1[i] << s1_rs2[i][$clog2(xlen)-1:0];
                op_srl:  s1_res[i] = s1_rs1[i] >> s1_rs2[i][$clog2(xlen)-1:0];
                op_sra:  s1_res[i] = $signed(s1_rs1[i]) >>> s1_rs2[i][$clog2(xlen)-1:0];
                op_slt:  s1_res[i] = {{(xlen-1){1'b0}}, $signed(s1_rs1[i]) < $signed(s1_rs2[i])};
                op_sltu: s1_res[i] = {{(xlen-1){1'b0}}, s1_rs1[i] < s1_rs2[i]};
                // Branches write the return address
                default: s1_res[i] = s1_pc + xlen'(4);
            endcase
        end
    end

    // Lane 0 is taken as the first active lane for the branch decision
    always_comb begin
        case (s1_op)
            op_beq:  branch_taken = s1_rs1[0] == s1_rs2[0];
            op_bne:  branch_taken = s1_rs1[0] != s1_rs2[0];
            op_blt:  branch_taken = $signed(s1_rs1[0]) < $signed(s1_rs2[0]);
            op_bge:  branch_taken = $signed(s1_rs1[0]) >= $signed(s1_rs2[0]);
            default: branch_taken = 1'b0;
        endcase
    end

    // One pulse per branch, on the cycle it moves into stage two
    assign branch_valid = s1_valid && s1_adv && is_branch(s1_op);
    assign branch_wid   = s1_wid;
    assign branch_dest  = s1_pc + s1_offset;

    // A reported branch shows up at the commit side one cycle later with its link value
    branch_commits: assert property (@(posedge clk) disable iff (reset)
        branch_valid |=> commit.valid && commit.pc == $past(s1_pc)
                         && commit.data[0] == $past(s1_pc) + xlen'(4));

endmodule

//--- design/muldiv_unit.sv
// Iterative multiply and divide unit, one instruction at a time over all lanes
`timescale 1ns/1ps

module muldiv_unit (
    input  logic     clk,
    input  logic     reset,
    execute_if.slave exec,
    commit_if.master commit
);
    import alu_pkg::*;

    logic                             busy;
    logic                             done;
    logic [4:0]                       cnt;
    md_op_e                           op;
    logic                             op_signed;
    logic                             in_signed;
    logic [num_lanes-1:0][xlen-1:0]   a;
    logic [num_lanes-1:0][xlen-1:0]   b;
    logic [num_lanes-1:0][xlen-1:0]   q;
    logic [num_lanes-1:0][xlen-1:0]   r;
    logic [num_lanes-1:0][xlen-1:0]   start_q;
    logic [num_lanes-1:0][xlen-1:0]   q_nxt;
    logic [num_lanes-1:0][xlen-1:0]   r_nxt;
    logic [num_lanes-1:0][xlen-1:0]   fin;
    logic [num_lanes-1:0][2*xlen-1:0] prod_u;
    logic [num_lanes-1:0][2*xlen-1:0] prod_s;
    logic [num_lanes-1:0][xlen-1:0]   r_res_hold;

    // A new instruction may enter on the cycle the previous result leaves
    assign exec.ready   = !busy && (!done || commit.ready);
    assign commit.valid = done;
    assign commit.data  = r_res_hold;

    assign op_signed = is_signed_div(op);
    assign in_signed = is_signed_div(exec.op.md);

    always_comb begin
        logic [xlen:0]   rem_sh;
        logic [xlen:0]   diff;
        logic [xlen-1:0] abs_b;
        logic            neg_q;
        logic            neg_r;
        for (int i = 0; i < num_lanes; i++) begin
            // The divide loop runs on magnitudes, the sign is put back at the end
            start_q[i] = (in_signed && exec.rs1_data[i][xlen-1]) ?
                         -exec.rs1_data[i] : exec.rs1_data[i];
            abs_b  = (op_signed && b[i][xlen-1]) ? -b[i] : b[i];
            rem_sh = {r[i], q[i][xlen-1]};
            diff   = rem_sh - {1'b0, abs_b};
            r_nxt[i] = diff[xlen] ? rem_sh[xlen-1:0] : diff[xlen-1:0];
            q_nxt[i] = {q[i][xlen-2:0], !diff[xlen]};
            neg_q  = op_signed && (a[i][xlen-1] ^ b[i][xlen-1]);
            neg_r  = op_signed && a[i][xlen-1];

            prod_u[i] = {{xlen{1'b0}}, a[i]} * {{xlen{1'b0}}, b[i]};
            prod_s[i] = {{xlen{a[i][xlen-1]}}, a[i]} * {{xlen{b[i][xlen-1]}}, b[i]};

            case (op)
                op_mul:   fin[i] = prod_u[i][xlen-1:0];
                op_mulh:  fin[i] = prod_s[i][2*xlen-1:xlen];
                op_mulhu: fin[i] = prod_u[i][2*xlen-1:xlen];
                // Zero divisor gives all ones, overflow falls out of the magnitude loop
                op_div, op_divu:
                    fin[i] = (b[i] == '0) ? '1 : (neg_q ? -q_nxt[i] : q_nxt[i]);
                default:  fin[i] = neg_r ? -r_nxt[i] : r_nxt[i];
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            if (commit.valid && commit.ready)
                done <= 1'b0;
            if (exec.valid && exec.ready) begin
                busy <= 1'b1;
            end else if (busy && (is_mul(op) || cnt == 5'd31)) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (exec.valid && exec.ready) begin
            op           <= exec.op.md;
            a            <= exec.rs1_data;
            b            <= exec.rs2_data;
            q            <= start_q;
            r            <= '0;
            cnt          <= '0;
            commit.uuid  <= exec.uuid;
            commit.wid   <= exec.wid;
            commit.tmask <= exec.tmask;
            commit.pc    <= exec.pc;
            commit.rd    <= exec.rd;
            commit.wb    <= exec.wb;
        end else if (busy) begin
            q          <= q_nxt;
            r          <= r_nxt;
            cnt        <= cnt + 5'd1;
            r_res_hold <= fin;
        end
    end

    // Once an instruction is taken no other enters before its result is handed off
    one_in_flight: assert property (@(posedge clk) disable iff (reset)
        (exec.valid && exec.ready) |=> !exec.ready until (commit.valid && commit.ready));

endmodule

//--- design/rsp_arb.sv
// Round-robin merge of the two unit result streams into one commit stream
`timescale 1ns/1ps

module rsp_arb (
    input  logic     clk,
    input  logic     reset,
    commit_if.slave  in_a,
    commit_if.slave  in_b,
    commit_if.master out
);

    logic grant_b;
    logic last_b;
    logic hold;

    // A stalled output keeps its source, otherwise the side not served last wins a tie
    always_comb begin
        if (hold)
            grant_b = last_b;
        else if (in_a.valid && in_b.valid)
            grant_b = !last_b;
        else
            grant_b = in_b.valid;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            last_b <= 1'b0;
            hold   <= 1'b0;
        end else begin
            hold <= out.valid && !out.ready;
            if (out.valid)
                last_b <= grant_b;
        end
    end

    assign in_a.ready = out.ready && !grant_b;
    assign in_b.ready = out.ready && grant_b;

    assign out.valid = grant_b ? in_b.valid : in_a.valid;
    assign out.uuid  = grant_b ? in_b.uuid  : in_a.uuid;
    assign out.wid   = grant_b ? in_b.wid   : in_a.wid;
    assign out.tmask = grant_b ? in_b.tmask : in_a.tmask;
    assign out.pc    = grant_b ? in_b.pc    : in_a.pc;
    assign out.rd    = grant_b ? in_b.rd    : in_a.rd;
    assign out.wb    = grant_b ? in_b.wb    : in_a.wb;
    assign out.data  = grant_b ? in_b.data  : in_a.data;

    grant_held: assert property (@(posedge clk) disable iff (reset)
        (out.valid && !out.ready) |=> grant_b == $past(grant_b));

    valid_has_source: assert property (@(posedge clk) disable iff (reset)
        out.valid |-> (in_a.valid || in_b.valid));

endmodule

//--- design/alu_unit.sv
// Scalar execute stage top, splits instructions by class and merges the results
`timescale 1ns/1ps

module alu_unit (
    input  logic                                          clk,
    input  logic                                          reset,

    input  logic                                          in_valid,
    output logic                                          in_ready,
    input  logic [alu_pkg::uuid_bits-1:0]                 in_uuid,
    input  logic [alu_pkg::wid_bits-1:0]                  in_wid,
    input  logic [alu_pkg::num_lanes-1:0]                 in_tmask,
    input  logic [alu_pkg::xlen-1:0]                      in_pc,
    input  logic [alu_pkg::nr_bits-1:0]                   in_rd,
    input  logic                                          in_wb,
    input  logic                                          in_is_md,
    input  alu_pkg::op_u                                  in_op,
    input  logic [alu_pkg::num_lanes-1:0][alu_pkg::xlen-1:0] in_rs1_data,
    input  logic [alu_pkg::num_lanes-1:0][alu_pkg::xlen-1:0] in_rs2_data,
    input  logic [alu_pkg::xlen-1:0]                      in_offset,

    output logic                                          out_valid,
    input  logic                                          out_ready,
    output logic [alu_pkg::uuid_bits-1:0]                 out_uuid,
    output logic [alu_pkg::wid_bits-1:0]                  out_wid,
    output logic [alu_pkg::num_lanes-1:0]                 out_tmask,
    output logic [alu_pkg::xlen-1:0]                      out_pc,
    output logic [alu_pkg::nr_bits-1:0]                   out_rd,
    output logic                                          out_wb,
    output logic [alu_pkg::num_lanes-1:0][alu_pkg::xlen-1:0] out_data,

    output logic                                          branch_valid,
    output logic [alu_pkg::wid_bits-1:0]                  branch_wid,
    output logic                                          branch_taken,
    output logic [alu_pkg::xlen-1:0]                      branch_dest
);

    // Index 0 is the integer path, index 1 the multiply/divide path
    execute_if exec_if [2] ();
    commit_if  unit_commit [2] ();
    commit_if  arb_out ();

    for (genvar g = 0; g < 2; g++) begin : g_route
        // Both units see the payload, only the selected class sees valid
        assign exec_if[g].valid    = in_valid && (in_is_md == 1'(g));
        assign exec_if[g].uuid     = in_uuid;
        assign exec_if[g].wid      = in_wid;
        assign exec_if[g].tmask    = in_tmask;
        assign exec_if[g].pc       = in_pc;
        assign exec_if[g].rd       = in_rd;
        assign exec_if[g].wb       = in_wb;
        assign exec_if[g].op       = in_op;
        assign exec_if[g].rs1_data = in_rs1_data;
        assign exec_if[g].rs2_data = in_rs2_data;
        assign exec_if[g].offset   = in_offset;
    end

    assign in_ready = in_is_md ? exec_if[1].ready : exec_if[0].ready;

    int_unit int_unit_i (
        .clk          (clk),
        .reset        (reset),
        .exec         (exec_if[0]),
        .commit       (unit_commit[0]),
        .branch_valid (branch_valid),
        .branch_wid   (branch_wid),
        .branch_taken (branch_taken),
        .branch_dest  (branch_dest)
    );

    muldiv_unit muldiv_unit_i (
        .clk    (clk),
        .reset  (reset),
        .exec   (exec_if[1]),
        .commit (unit_commit[1])
    );

    rsp_arb rsp_arb_i (
        .clk   (clk),
        .reset (reset),
        .in_a  (unit_commit[0]),
        .in_b  (unit_commit[1]),
        .out   (arb_out)
    );

    assign out_valid     = arb_out.valid;
    assign arb_out.ready = out_ready;
    assign out_uuid      = arb_out.uuid;
    assign out_wid       = arb_out.wid;
    assign out_tmask     = arb_out.tmask;
    assign out_pc        = arb_out.pc;
    assign out_rd        = arb_out.rd;
    assign out_wb        = arb_out.wb;
    assign out_data      = arb_out.data;

endmodule

//--- tb/tb_alu_unit.sv
// Testbench for the scalar execute stage with random traffic, a tag scoreboard and assertions
`timescale 1ns/1ps

module tb_alu_unit;
    import alu_pkg::*;

    localparam int num_instr    = 240;
    localparam int accept_wait  = 200;
    localparam int drain_wait   = 4000;
    localparam int payload_bits = uuid_bits + wid_bits + num_lanes + xlen + nr_bits + 1
                                  + num_lanes * xlen;

    logic                           clk;
    logic                           reset;
    logic                           in_valid;
    logic                           in_ready;
    logic [uuid_bits-1:0]           in_uuid;
    logic [wid_bits-1:0]            in_wid;
    logic [num_lanes-1:0]           in_tmask;
    logic [xlen-1:0]                in_pc;
    logic [nr_bits-1:0]             in_rd;
    logic                           in_wb;
    logic                           in_is_md;
    op_u                            in_op;
    logic [num_lanes-1:0][xlen-1:0] in_rs1_data;
    logic [num_lanes-1:0][xlen-1:0] in_rs2_data;
    logic [xlen-1:0]                in_offset;
    logic                           out_valid;
    logic                           out_ready;
    logic [uuid_bits-1:0]           out_uuid;
    logic [wid_bits-1:0]            out_wid;
    logic [num_lanes-1:0]           out_tmask;
    logic [xlen-1:0]                out_pc;
    logic [nr_bits-1:0]             out_rd;
    logic                           out_wb;
    logic [num_lanes-1:0][xlen-1:0] out_data;
    logic                           branch_valid;
    logic [wid_bits-1:0]            branch_wid;
    logic                           branch_taken;
    logic [xlen-1:0]                branch_dest;
    logic [payload_bits-1:0]        out_payload;

    // Scoreboard indexed by uuid, and a queue of expected branch pulses in issue order
    logic                           pending   [256] = '{default: 1'b0};
    logic [num_lanes-1:0][xlen-1:0] exp_data  [256];
    logic [wid_bits-1:0]            exp_wid   [256];
    logic [nr_bits-1:0]             exp_rd    [256];
    logic [num_lanes-1:0]           exp_tmask [256];
    logic [xlen-1:0]                exp_pc    [256];
    logic                           exp_wb    [256];
    logic [wid_bits-1:0]            br_wid    [256];
    logic                           br_taken  [256];
    logic [xlen-1:0]                br_dest   [256];
    int                             br_head        = 0;
    int                             br_tail        = 0;
    int                             accepted       = 0;
    int                             committed      = 0;
    int                             data_errors    = 0;
    int                             tag_errors     = 0;
    int                             timeout_errors = 0;
    integer                         seed           = 32'h252b;
    integer                         stall_seed     = 32'h252b;

    alu_unit dut_i (.*);

    assign out_payload = {out_uuid, out_wid, out_tmask, out_pc, out_rd, out_wb, out_data};

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [xlen-1:0] pick_operand();
        logic [2:0] kind;
        kind = 3'($random(seed));
        case (kind)
            3'd0:    return '0;
            3'd1:    return {1'b1, {(xlen-1){1'b0}}};
            3'd2:    return '1;
            3'd3:    return xlen'($random(seed) & 31);
            default: return xlen'($random(seed));
        endcase
    endfunction

    function automatic logic branch_outcome(alu_op_e op, logic [xlen-1:0] a, logic [xlen-1:0] b);
        case (op)
            op_beq:  return a == b;
            op_bne:  return a != b;
            op_blt:  return $signed(a) < $signed(b);
            default: return $signed(a) >= $signed(b);
        endcase
    endfunction

    // Reference result of one lane, written straight from the operation rules
    function automatic logic [xlen-1:0] lane_result(logic md, op_u op, logic [xlen-1:0] a,
                                                    logic [xlen-1:0] b, logic [xlen-1:0] pc);
        logic [xlen-1:0]   res;
        logic [2*xlen-1:0] wide;
        longint            sa;
        longint            sb;
        logic              ovf;
        sa  = $signed(a);
        sb  = $signed(b);
        ovf = (a == {1'b1, {(xlen-1){1'b0}}}) && (b == '1);
        if (md) begin
            case (op.md)
                op_mul:   res = a * b;
                op_mulh: begin
                    wide = sa * sb;
                    res  = wide[2*xlen-1:xlen];
                end
                op_mulhu: begin
                    wide = {{xlen{1'b0}}, a} * {{xlen{1'b0}}, b};
                    res  = wide[2*xlen-1:xlen];
                end
                op_div: begin
                    if (b == '0)
                        res = '1;
                    else if (ovf)
                        res = a;
                    else
                        res = sa / sb;
                end
                op_divu:  res = (b == '0) ? '1 : a / b;
                op_rem: begin
                    if (b == '0)
                        res = a;
                    else if (ovf)
                        res = '0;
                    else
                        res = sa % sb;
                end
                default:  res = (b == '0) ? a : a % b;
            endcase
        end else begin
            case (op.alu)
                op_add:  res = a + b;
                op_sub:  res = a - b;
                op_and:  res = a & b;
                op_or:   res = a | b;
                op_xor:  res = a ^ b;
                op_sll:  res = a << b[4:0];
                op_srl:  res = a >> b[4:0];
                op_sra:  res = $signed(a) >>> b[4:0];
                op_slt:  res = ($signed(a) < $signed(b)) ? 1 : 0;
                op_sltu: res = (a < b) ? 1 : 0;
                default: res = pc + 4;
            endcase
        end
        return res;
    endfunction

    task automatic drive_instr(input int n);
        logic                           md;
        logic [3:0]                     code;
        logic [num_lanes-1:0]           mask;
        logic [num_lanes-1:0][xlen-1:0] a;
        logic [num_lanes-1:0][xlen-1:0] b;
        md = 1'($random(seed));
        code = md ? 4'($unsigned($random(seed)) % 7) : 4'($unsigned($random(seed)) % 14);
        for (int i = 0; i < num_lanes; i++) begin
            a[i] = pick_operand();
            b[i] = pick_operand();
        end
        // The first two instructions pin signed overflow in lane 0 and a zero divisor in lane 1
        if (n < 2) begin
            md   = 1'b1;
            code = (n == 0) ? op_div : op_rem;
            a[0] = {1'b1, {(xlen-1){1'b0}}};
            b[0] = '1;
            b[1] = '0;
        end
        mask = num_lanes'($random(seed));
        if (mask == '0)
            mask = '1;
        in_valid    <= 1'b1;
        in_uuid     <= uuid_bits'(n);
        in_wid      <= wid_bits'($random(seed));
        in_tmask    <= mask;
        in_pc       <= xlen'($random(seed)) & ~xlen'(3);
        in_rd       <= nr_bits'($random(seed));
        in_wb       <= 1'($random(seed));
        in_is_md    <= md;
        in_op       <= op_u'(code);
        in_rs1_data <= a;
        in_rs2_data <= b;
        in_offset   <= xlen'($random(seed)) & ~xlen'(3);
    endtask

    // Record every accepted instruction and retire it on commit
    always @(posedge clk) begin
        logic [num_lanes-1:0][xlen-1:0] lanes;
        if (!reset && in_valid && in_ready) begin
            for (int i = 0; i < num_lanes; i++)
                lanes[i] = lane_result(in_is_md, in_op, in_rs1_data[i], in_rs2_data[i], in_pc);
            pending[in_uuid]   <= 1'b1;
            exp_data[in_uuid]  <= lanes;
            exp_wid[in_uuid]   <= in_wid;
            exp_rd[in_uuid]    <= in_rd;
            exp_tmask[in_uuid] <= in_tmask;
            exp_pc[in_uuid]    <= in_pc;
            exp_wb[in_uuid]    <= in_wb;
            accepted           <= accepted + 1;
            if (!in_is_md && in_op.alu inside {op_beq, op_bne, op_blt, op_bge}) begin
                br_wid[br_tail]   <= in_wid;
                br_taken[br_tail] <= branch_outcome(in_op.alu, in_rs1_data[0], in_rs2_data[0]);
                br_dest[br_tail]  <= in_pc + in_offset;
                br_tail           <= br_tail + 1;
            end
        end
        if (!reset && out_valid && out_ready) begin
            pending[out_uuid] <= 1'b0;
            committed         <= committed + 1;
        end
        if (!reset && branch_valid)
            br_head <= br_head + 1;
    end

    // The consumer stalls about one cycle in four
    always @(posedge clk) begin
        if (reset)
            out_ready <= 1'b0;
        else
            out_ready <= ($random(stall_seed) & 3) != 0;
    end

    commit_known: assert property (@(posedge clk) disable iff (reset)
        (out_valid && out_ready) |-> pending[out_uuid])
    else begin
        tag_errors++;
        $display("uuid %h committed but was never accepted or already committed",
                 $sampled(out_uuid));
    end

    commit_data: assert property (@(posedge clk) disable iff (reset)
        (out_valid && out_ready && pending[out_uuid]) |-> out_data == exp_data[out_uuid])
    else begin
        data_errors++;
        $display("error out_data uuid %h got %h expected %h", $sampled(out_uuid),
                 $sampled(out_data), exp_data[$sampled(out_uuid)]);
    end

    commit_fields: assert property (@(posedge clk) disable iff (reset)
        (out_valid && out_ready && pending[out_uuid]) |->
            out_wid == exp_wid[out_uuid] && out_rd == exp_rd[out_uuid]
            && out_tmask == exp_tmask[out_uuid] && out_pc == exp_pc[out_uuid]
            && out_wb == exp_wb[out_uuid])
    else begin
        data_errors++;
        $display("error out_wid/out_rd/out_tmask/out_pc/out_wb uuid %h got %h %h %h %h %h",
                 $sampled(out_uuid), $sampled(out_wid), $sampled(out_rd),
                 $sampled(out_tmask), $sampled(out_pc), $sampled(out_wb));
    end

    branch_expected: assert property (@(posedge clk) disable iff (reset)
        branch_valid |-> br_head != br_tail)
    else begin
        tag_errors++;
        $display("branch pulse seen with no branch instruction outstanding");
    end

    branch_fields: assert property (@(posedge clk) disable iff (reset)
        (branch_valid && br_head != br_tail) |->
            branch_wid == br_wid[br_head] && branch_taken == br_taken[br_head]
            && branch_dest == br_dest[br_head])
    else begin
        data_errors++;
        $display("error branch_wid/branch_taken/branch_dest got %h %h %h expected %h %h %h",
                 $sampled(branch_wid), $sampled(branch_taken), $sampled(branch_dest),
                 br_wid[$sampled(br_head)], br_taken[$sampled(br_head)],
                 br_dest[$sampled(br_head)]);
    end

    stall_holds: assert property (@(posedge clk) disable iff (reset)
        (out_valid && !out_ready) |=> out_valid && $stable(out_payload))
    else begin
        data_errors++;
        $display("error out_valid/out_payload changed under stall, now %h %h",
                 $sampled(out_valid), $sampled(out_payload));
    end

    reset_quiet: assert property (@(posedge clk)
        $fell(reset) |-> !out_valid && !branch_valid)
    else begin
        data_errors++;
        $display("error out_valid/branch_valid after reset release got %h %h",
                 $sampled(out_valid), $sampled(branch_valid));
    end

    initial begin
        int   wait_cnt;
        logic stuck;
        stuck       = 1'b0;
        reset       = 1'b1;
        in_valid    = 1'b0;
        in_uuid     = '0;
        in_wid      = '0;
        in_tmask    = '0;
        in_pc       = '0;
        in_rd       = '0;
        in_wb       = 1'b0;
        in_is_md    = 1'b0;
        in_op       = '0;
        in_rs1_data = '0;
        in_rs2_data = '0;
        in_offset   = '0;
        out_ready   = 1'b0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        for (int n = 0; n < num_instr && !stuck; n++) begin
            if (($random(seed) & 7) == 0) begin
                in_valid <= 1'b0;
                @(posedge clk);
            end
            drive_instr(n);
            wait_cnt = 0;
            do begin
                @(posedge clk);
                wait_cnt++;
            end while (!in_ready && wait_cnt < accept_wait);
            if (!in_ready) begin
                stuck = 1'b1;
                timeout_errors++;
                $display("in_ready stayed low too long at instruction %0d", n);
            end
        end
        in_valid <= 1'b0;

        // Let every accepted instruction commit, then watch a while for stray results
        wait_cnt = 0;
        while (committed != accepted && wait_cnt < drain_wait) begin
            @(posedge clk);
            wait_cnt++;
        end
        repeat (20) @(posedge clk);
        if (committed != accepted) begin
            timeout_errors++;
            $display("%0d results never committed", accepted - committed);
        end
        if (accepted != num_instr) begin
            tag_errors++;
            $display("only %0d of %0d instructions were accepted", accepted, num_instr);
        end
        if (br_head != br_tail) begin
            tag_errors++;
            $display("%0d branch pulses are missing", br_tail - br_head);
        end

        $display("errors: data %0d, tracking %0d, timeout %0d",
                 data_errors, tag_errors, timeout_errors);
        if (data_errors + tag_errors + timeout_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- sources.f
design/alu_pkg.sv
design/execute_if.sv
design/commit_if.sv
design/int_unit.sv
design/muldiv_unit.sv
design/rsp_arb.sv
design/alu_unit.sv
tb/tb_alu_unit.sv

//--- Bender.yml
package:
  name: alu_unit

sources:
  - design/alu_pkg.sv
  - design/execute_if.sv
  - design/commit_if.sv
  - design/int_unit.sv
  - design/muldiv_unit.sv
  - design/rsp_arb.sv
  - design/alu_unit.sv
  - target: test
    files:
      - tb/tb_alu_unit.sv
